//--- bench/switch_core_tb.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module switch_core_tb;

	localparam int NP = `SW_NETH;
	localparam int NTBL = 1 << `SW_LGTBL;
	localparam int QD = 64;
	localparam int SETTLE = 12;
	localparam int FRAME_LIMIT = 300;
	localparam int EW = `SW_BEATW + `SW_BYTEW + 1;

	logic i_clk;
	logic i_arst_n;
	logic [NP-1:0] i_rx_valid;
	logic [NP-1:0] o_rx_ready;
	logic [NP-1:0][`SW_BEATW-1:0] i_rx_data;
	logic [NP-1:0][`SW_BYTEW-1:0] i_rx_bytes;
	logic [NP-1:0] i_rx_last;
	logic [NP-1:0] o_tx_valid;
	logic [NP-1:0] i_tx_ready;
	logic [NP-1:0][`SW_BEATW-1:0] o_tx_data;
	logic [NP-1:0][`SW_BYTEW-1:0] o_tx_bytes;
	logic [NP-1:0] o_tx_last;

	// Stimulus records, header word then beat words
	logic [`SW_BEATW-1:0] stim [0:63];
	// Expected beats per output as {data, bytes, last}
	logic [EW-1:0] exp_beat [NP][QD];
	int exp_head [NP];
	int exp_tail [NP];
	// Reference route table
	logic [`SW_MACW-1:0] mdl_mac [NTBL];
	int mdl_port [NTBL];
	logic [NTBL-1:0] mdl_vld;
	int mdl_rr;

	int errors;
	int cycles;
	int cycle_limit = 100000;
	int idle_cnt;
	int idx;
	int next_idx;
	int total;
	logic bp_on;

	switch_core switch_core_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rx_valid(i_rx_valid),
		.o_rx_ready(o_rx_ready),
		.i_rx_data(i_rx_data),
		.i_rx_bytes(i_rx_bytes),
		.i_rx_last(i_rx_last),
		.o_tx_valid(o_tx_valid),
		.i_tx_ready(i_tx_ready),
		.o_tx_data(o_tx_data),
		.o_tx_bytes(o_tx_bytes),
		.o_tx_last(o_tx_last)
	);

	// 40 ns clock
	always #20 i_clk = ~i_clk;

	// Run limit
	always @(posedge i_clk)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, frames did not get through", cycles);
			$display("tests failed");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [`SW_BEATW-1:0] expv,
		input logic [`SW_BEATW-1:0] actv);
		if (actv !== expv)
		begin
			errors++;
			$display("[FAIL] %s expected %h got %h", name, expv, actv);
		end
	endtask

	task automatic score_beat(input int o);
		logic [EW-1:0] e;
		if (exp_head[o] == exp_tail[o])
		begin
			errors++;
			$display("Unexpected beat on port %0d with data %h", o, o_tx_data[o]);
		end
		else
		begin
			e = exp_beat[o][exp_head[o] % QD];
			exp_head[o]++;
			compare_value($sformatf("o_tx_data[%0d]", o), e[EW-1 -: `SW_BEATW], o_tx_data[o]);
			compare_value($sformatf("o_tx_bytes[%0d]", o), e[`SW_BYTEW:1], o_tx_bytes[o]);
			compare_value($sformatf("o_tx_last[%0d]", o), e[0], o_tx_last[o]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	//
	// Transmit side, ready drive and output monitor
	//
	////////////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		for (int o = 0; o < NP; o++)
			i_tx_ready[o] = bp_on ? (($urandom % 4) != 0) : 1'b1;
		// Mid low phase, all inputs settled until the next rising edge
		#10;
		for (int o = 0; o < NP; o++)
			if (o_tx_valid[o] && i_tx_ready[o])
				score_beat(o);
		if (|o_tx_valid)
			idle_cnt = 0;
		else
			idle_cnt = idle_cnt + 1;
	end

	// Reference table, known MAC moves, new MAC takes the round-robin slot
	task automatic learn_source(input logic [`SW_MACW-1:0] mac, input int port);
		int hit;
		hit = -1;
		for (int e = 0; e < NTBL; e++)
			if (mdl_vld[e] && (mdl_mac[e] == mac))
				hit = e;
		if (hit >= 0)
			mdl_port[hit] = port;
		else
		begin
			mdl_mac[mdl_rr] = mac;
			mdl_port[mdl_rr] = port;
			mdl_vld[mdl_rr] = 1'b1;
			mdl_rr = (mdl_rr + 1) % NTBL;
		end
	endtask

	// Miss or broadcast floods, source port always removed
	function automatic logic [NP-1:0] route_lookup(input logic [`SW_MACW-1:0] mac,
		input int src);
		logic [NP-1:0] mask;
		mask = '1;
		if (mac != '1)
			for (int e = 0; e < NTBL; e++)
				if (mdl_vld[e] && (mdl_mac[e] == mac))
				begin
					mask = '0;
					mask[mdl_port[e]] = 1'b1;
				end
		mask[src] = 1'b0;
		return mask;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	//
	// Frame sender and settle wait
	//
	////////////////////////////////////////////////////////////////////////////

	task automatic send_frame(input int base, output int next);
		logic [`SW_BEATW-1:0] hdr;
		logic [`SW_BYTEW-1:0] lastb;
		logic [`SW_BYTEW-1:0] nbytes;
		logic [NP-1:0] mask;
		int port;
		int nbeat;
		hdr = stim[base];
		lastb = hdr[19:16];
		port = hdr[15:12];
		nbeat = hdr[11:8];
		bp_on = hdr[4];
		// Source is learned on the first beat, ahead of the lookup
		learn_source(stim[base+1][`SW_BEATW-1-`SW_MACW -: `SW_MACW], port);
		mask = route_lookup(stim[base+1][`SW_BEATW-1 -: `SW_MACW], port);
		compare_value("destination mask", hdr[3:0], mask);
		for (int b = 0; b < nbeat; b++)
		begin
			nbytes = (b == nbeat - 1) ? lastb : '0;
			for (int o = 0; o < NP; o++)
				if (mask[o])
				begin
					exp_beat[o][exp_tail[o] % QD] = {stim[base+1+b], nbytes, b == nbeat - 1};
					exp_tail[o]++;
				end
		end
		for (int b = 0; b < nbeat; b++)
		begin
			@(negedge i_clk);
			i_rx_valid[port] = 1'b1;
			i_rx_data[port] = stim[base+1+b];
			i_rx_bytes[port] = (b == nbeat - 1) ? lastb : '0;
			i_rx_last[port] = (b == nbeat - 1);
			// Beat moves on the rising edge after ready is seen high
			while (!o_rx_ready[port])
				@(negedge i_clk);
		end
		@(negedge i_clk);
		i_rx_valid[port] = 1'b0;
		i_rx_last[port] = 1'b0;
		next = base + 1 + nbeat;
	endtask

	task automatic wait_settle();
		int waited;
		logic pending;
		waited = 0;
		pending = 1'b1;
		while (pending && (waited < FRAME_LIMIT))
		begin
			@(posedge i_clk);
			waited++;
			pending = (idle_cnt < SETTLE) || (waited < SETTLE);
			for (int o = 0; o < NP; o++)
				if (exp_head[o] != exp_tail[o])
					pending = 1'b1;
		end
		for (int o = 0; o < NP; o++)
			if (exp_head[o] != exp_tail[o])
			begin
				errors++;
				$display("Port %0d is missing %0d expected beats", o, exp_tail[o] - exp_head[o]);
				exp_head[o] = exp_tail[o];
			end
		bp_on = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32624));
		i_clk = 1'b0;
		i_arst_n = 1'b0;
		i_rx_valid = '0;
		i_rx_data = '0;
		i_rx_bytes = '0;
		i_rx_last = '0;
		i_tx_ready = '1;
		errors = 0;
		cycles = 0;
		idle_cnt = 0;
		bp_on = 1'b0;
		mdl_vld = '0;
		mdl_rr = 0;
		for (int o = 0; o < NP; o++)
		begin
			exp_head[o] = 0;
			exp_tail[o] = 0;
		end
		$readmemh("bench/switch_stim.hex", stim);
		// Beat total sets the run limit
		total = 0;
		idx = 0;
		while (stim[idx][11:8] != 0)
		begin
			total = total + stim[idx][11:8];
			idx = idx + 1 + stim[idx][11:8];
		end
		cycle_limit = 20 * total + 200;
		repeat (2) @(negedge i_clk);
		i_arst_n = 1'b1;
		idx = 0;
		while (stim[idx][11:8] != 0)
		begin
			send_frame(idx, next_idx);
			wait_settle();
			idx = next_idx;
		end
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- bench/switch_stim.hex
// Header: last-beat bytes, source port, beat count, back-pressure flag, expected dest mask
// Beats: 128 bits each, first beat holds destination MAC then source MAC
// Port 0, A to unknown B, floods
8020E
02000000000B02000000000A11110001
11110002111100031111000411110005
// Port 1, B to A, learned on port 0
41301
02000000000A02000000000B22220001
22220002222200032222000422220005
22220006222200072222000822220009
C2101
02000000000A02000000000C33330001
// Port 0 to A on its own port, dropped
00200
02000000000A02000000000D44440001
44440002444400034444000444440005
// Broadcast from port 3, then again from port 1
23207
FFFFFFFFFFFF02000000000E55550001
55550002555500035555000455550005
6110D
FFFFFFFFFFFF02000000000B66660001
// A moves to port 2, then port 3 sends to A
A2100
02000000000C02000000000A77770001
03204
02000000000A02000000000E88880001
88880002888800038888000488880005
// Random transmit back-pressure
3141D
02000000000F02000000000B99990001
99990002999900039999000499990005
99990006999900079999000899990009
9999000A9999000B9999000C9999000D
00318
02000000000E02000000000DAAAA0001
AAAA0002AAAA0003AAAA0004AAAA0005
AAAA0006AAAA0007AAAA0008AAAA0009
00000

//--- build.f
+incdir+hdl
hdl/sw_pkg.sv
hdl/rx_srcmac_tap.sv
hdl/pkt_fifo.sv
hdl/route_table.sv
hdl/tx_port_lookup.sv
hdl/tx_crossbar.sv
hdl/switch_core.sv
bench/switch_core_tb.sv

//--- hdl/pkt_fifo.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module pkt_fifo
	import sw_pkg::*;
#(
	parameter type T_PAYLOAD = beat_t
)
(
	input logic i_clk,
	input logic i_arst_n,
	// Write side
	input logic i_wr_valid,
	output logic o_wr_ready,
	input T_PAYLOAD i_wr_data,
	// Read side
	output logic o_rd_valid,
	input logic i_rd_ready,
	output T_PAYLOAD o_rd_data
);

	localparam int DEPTH = 1 << `SW_LGFIFO;

	T_PAYLOAD mem [DEPTH];
	logic [`SW_LGFIFO-1:0] wr_ptr;
	logic [`SW_LGFIFO-1:0] rd_ptr;
	logic [`SW_LGFIFO:0] count;
	logic full;
	logic empty;
	logic do_wr;
	logic do_rd;

	// Top count bit is set only at DEPTH entries
	assign full = count[`SW_LGFIFO];
	assign empty = (count == '0);

	assign o_wr_ready = !full;
	assign o_rd_valid = !empty;
	assign do_wr = i_wr_valid && o_wr_ready;
	assign do_rd = i_rd_ready && o_rd_valid;

	// Head entry read straight from storage
	assign o_rd_data = mem[rd_ptr];

	always_ff @(posedge i_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_data;
	end

	// Pointers wrap naturally at DEPTH
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// A full buffer never advances its write side
	a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		full && !do_rd |=> $stable(wr_ptr) && full);

	// An empty buffer never advances its read side
	a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		empty && !do_wr |=> $stable(rd_ptr) && empty);

endmodule

//--- hdl/route_table.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module route_table
	import sw_pkg::*;
(
	input logic i_clk,
	input logic i_arst_n,
	// Learn requests, one per port
	input portmask_t i_learn_valid,
	output portmask_t o_learn_ready,
	input mac_t [`SW_NETH-1:0] i_learn_mac,
	input portidx_t [`SW_NETH-1:0] i_learn_port,
	// Lookup requests, one per port
	input portmask_t i_lkup_req,
	input mac_t [`SW_NETH-1:0] i_lkup_mac,
	output portmask_t o_lkup_ack,
	output portmask_t o_lkup_mask
);

	localparam int NTBL = 1 << `SW_LGTBL;

	// Table storage
	mac_t tbl_mac [NTBL];
	portidx_t tbl_port [NTBL];
	logic [NTBL-1:0] tbl_vld;
	logic [`SW_LGTBL-1:0] rr_ptr;

	// Learn side
	logic lrn_any;
	portidx_t lrn_sel;
	mac_t lrn_mac;
	logic [NTBL-1:0] lrn_hit;
	logic [`SW_LGTBL-1:0] lrn_idx;

	// Lookup side
	portmask_t lk_elig;
	logic lk_any;
	portidx_t lk_sel;
	mac_t lk_mac;
	logic [NTBL-1:0] lk_hit;
	logic [`SW_LGTBL-1:0] lk_idx;
	portmask_t lk_mask;

	////////////////////////////////////////////////////////////////////////////
	//
	// Request selection and parallel compare
	//
	////////////////////////////////////////////////////////////////////////////

	// Port already being answered is not served twice
	assign lk_elig = i_lkup_req & ~o_lkup_ack;

	always_comb
	begin
		lrn_any = 1'b0;
		lrn_sel = '0;
		lk_any = 1'b0;
		lk_sel = '0;
		// Downward scan leaves the lowest port selected
		for (int p = `SW_NETH-1; p >= 0; p--)
		begin
			if (i_learn_valid[p])
			begin
				lrn_any = 1'b1;
				lrn_sel = portidx_t'(p);
			end
			if (lk_elig[p])
			begin
				lk_any = 1'b1;
				lk_sel = portidx_t'(p);
			end
		end
		lrn_mac = i_learn_mac[lrn_sel];
		lk_mac = i_lkup_mac[lk_sel];

		// Compare both addresses against every entry
		lrn_idx = '0;
		lk_idx = '0;
		for (int e = NTBL-1; e >= 0; e--)
		begin
			lrn_hit[e] = tbl_vld[e] && (tbl_mac[e] == lrn_mac);
			lk_hit[e] = tbl_vld[e] && (tbl_mac[e] == lk_mac);
			if (lrn_hit[e])
				lrn_idx = e[`SW_LGTBL-1:0];
			if (lk_hit[e])
				lk_idx = e[`SW_LGTBL-1:0];
		end

		// Miss or broadcast floods to every port
		if (&lk_mac || !(|lk_hit))
			lk_mask = '1;
		else
			lk_mask = portmask_t'(1) << tbl_port[lk_idx];
		// Never send a frame back where it came from
		lk_mask = lk_mask & ~(portmask_t'(1) << lk_sel);
	end

	assign o_learn_ready = portmask_t'(lrn_any) << lrn_sel;

	////////////////////////////////////////////////////////////////////////////
	//
	// Table update and registered answer
	//
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// Known address moves, new address takes the round-robin slot
		if (lrn_any && (|lrn_hit))
			tbl_port[lrn_idx] <= i_learn_port[lrn_sel];
		else if (lrn_any)
		begin
			tbl_mac[rr_ptr] <= lrn_mac;
			tbl_port[rr_ptr] <= i_learn_port[lrn_sel];
		end
		if (lk_any)
			o_lkup_mask <= lk_mask;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			tbl_vld <= '0;
			rr_ptr <= '0;
			o_lkup_ack <= '0;
		end
		else
		begin
			if (lrn_any && !(|lrn_hit))
			begin
				tbl_vld[rr_ptr] <= 1'b1;
				rr_ptr <= rr_ptr + 1'b1;
			end
			// Acknowledge pulse one cycle after the request is served
			o_lkup_ack <= portmask_t'(lk_any) << lk_sel;
		end
	end

	// At most one acknowledge bit and only toward a port still waiting on it
	a_ack_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		$onehot0(o_lkup_ack) && ((o_lkup_ack & ~i_lkup_req) == '0));

endmodule

//--- hdl/rx_srcmac_tap.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module rx_srcmac_tap
	import sw_pkg::*;
#(
	parameter int P_PORT = 0
)
(
	input logic i_clk,
	input logic i_arst_n,
	// Receive stream from the port
	input logic i_rx_valid,
	output logic o_rx_ready,
	input logic [`SW_BEATW-1:0] i_rx_data,
	input logic [`SW_BYTEW-1:0] i_rx_bytes,
	input logic i_rx_last,
	// Registered beats toward the frame FIFO
	output logic o_fifo_valid,
	input logic i_fifo_ready,
	output beat_t o_fifo_beat,
	// Learn request toward the route table
	output logic o_learn_valid,
	input logic i_learn_ready,
	output mac_t o_learn_mac,
	output portidx_t o_learn_port
);

	logic rx_en;
	logic sof;
	logic rx_fire;

	// Accept when the output register is free and no learn is pending
	assign o_rx_ready = rx_en && !o_learn_valid && (!o_fifo_valid || i_fifo_ready);
	assign rx_fire = i_rx_valid && o_rx_ready;

	// Every learn carries this port's number
	assign o_learn_port = portidx_t'(P_PORT);

	// Control state
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			rx_en <= 1'b0;
			sof <= 1'b1;
			o_fifo_valid <= 1'b0;
			o_learn_valid <= 1'b0;
		end
		else
		begin
			// Receive opens one cycle out of reset
			rx_en <= 1'b1;

			if (rx_fire)
				o_fifo_valid <= 1'b1;
			else if (i_fifo_ready)
				o_fifo_valid <= 1'b0;

			// Next beat after a last beat starts a new frame
			if (rx_fire)
				sof <= i_rx_last;

			// Learn request held until the table takes it
			if (rx_fire && sof)
				o_learn_valid <= 1'b1;
			else if (i_learn_ready)
				o_learn_valid <= 1'b0;
		end
	end

	// Beat and MAC payload registers
	always_ff @(posedge i_clk)
	begin
		if (rx_fire)
		begin
			o_fifo_beat.data <= i_rx_data;
			o_fifo_beat.bytes <= i_rx_bytes;
			o_fifo_beat.last <= i_rx_last;
		end
		// Source MAC is bytes 6 to 11 of the first beat
		if (rx_fire && sof)
			o_learn_mac <= i_rx_data[`SW_BEATW-1-`SW_MACW -: `SW_MACW];
	end

endmodule

//--- hdl/sw_defines.svh
`ifndef SW_DEFINES_SVH
`define SW_DEFINES_SVH

// Number of switch ports
`define SW_NETH 4

// Bits per frame beat
`define SW_BEATW 128

// Valid byte count of the last beat
// A count of zero stands for a full beat
`define SW_BYTEW 4

// Bits in one MAC address
`define SW_MACW 48

// Log2 of route table entries
`define SW_LGTBL 4

// Log2 of frame FIFO depth in beats
`define SW_LGFIFO 5

`endif

//--- hdl/sw_pkg.sv
`include "sw_defines.svh"

package sw_pkg;

	////////////////////////////////////////////////////////////////////////////
	//
	// Shared switch types
	//
	////////////////////////////////////////////////////////////////////////////

	// One MAC address
	typedef logic [`SW_MACW-1:0] mac_t;

	// One bit per switch port
	// Bit n set means port n is a destination
	typedef logic [`SW_NETH-1:0] portmask_t;

	// Index of a single port
	typedef logic [$clog2(`SW_NETH)-1:0] portidx_t;

	// One frame beat as stored in the FIFO
	// Byte 0 sits in the top bits of data
	typedef struct packed
	{
		logic [`SW_BEATW-1:0] data;
		logic [`SW_BYTEW-1:0] bytes;
		logic last;
	} beat_t;

endpackage

//--- hdl/switch_core.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module switch_core
	import sw_pkg::*;
(
	input logic i_clk,
	input logic i_arst_n,
	// Receive ports
	input logic [`SW_NETH-1:0] i_rx_valid,
	output logic [`SW_NETH-1:0] o_rx_ready,
	input logic [`SW_NETH-1:0][`SW_BEATW-1:0] i_rx_data,
	input logic [`SW_NETH-1:0][`SW_BYTEW-1:0] i_rx_bytes,
	input logic [`SW_NETH-1:0] i_rx_last,
	// Transmit ports
	output logic [`SW_NETH-1:0] o_tx_valid,
	input logic [`SW_NETH-1:0] i_tx_ready,
	output logic [`SW_NETH-1:0][`SW_BEATW-1:0] o_tx_data,
	output logic [`SW_NETH-1:0][`SW_BYTEW-1:0] o_tx_bytes,
	output logic [`SW_NETH-1:0] o_tx_last
);

	// Tap to FIFO
	portmask_t wr_valid;
	portmask_t wr_ready;
	beat_t [`SW_NETH-1:0] wr_beat;
	// FIFO to lookup
	portmask_t rd_valid;
	portmask_t rd_ready;
	beat_t [`SW_NETH-1:0] rd_beat;
	// Learning path
	portmask_t learn_valid;
	portmask_t learn_ready;
	mac_t [`SW_NETH-1:0] learn_mac;
	portidx_t [`SW_NETH-1:0] learn_port;
	// Lookup path
	portmask_t lkup_req;
	portmask_t lkup_ack;
	portmask_t lkup_mask;
	mac_t [`SW_NETH-1:0] lkup_mac;
	// Crossbar sources
	portmask_t src_valid;
	portmask_t src_ready;
	beat_t [`SW_NETH-1:0] src_beat;
	portmask_t [`SW_NETH-1:0] src_mask;

	////////////////////////////////////////////////////////////////////////////
	//
	// Per-port receive, buffer and lookup
	//
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `SW_NETH; g++)
	begin : g_port
		rx_srcmac_tap #(
			.P_PORT(g)
		) rx_srcmac_tap_inst (
			.i_clk(i_clk),
			.i_arst_n(i_arst_n),
			.i_rx_valid(i_rx_valid[g]),
			.o_rx_ready(o_rx_ready[g]),
			.i_rx_data(i_rx_data[g]),
			.i_rx_bytes(i_rx_bytes[g]),
			.i_rx_last(i_rx_last[g]),
			.o_fifo_valid(wr_valid[g]),
			.i_fifo_ready(wr_ready[g]),
			.o_fifo_beat(wr_beat[g]),
			.o_learn_valid(learn_valid[g]),
			.i_learn_ready(learn_ready[g]),
			.o_learn_mac(learn_mac[g]),
			.o_learn_port(learn_port[g])
		);

		pkt_fifo #(
			.T_PAYLOAD(beat_t)
		) pkt_fifo_inst (
			.i_clk(i_clk),
			.i_arst_n(i_arst_n),
			.i_wr_valid(wr_valid[g]),
			.o_wr_ready(wr_ready[g]),
			.i_wr_data(wr_beat[g]),
			.o_rd_valid(rd_valid[g]),
			.i_rd_ready(rd_ready[g]),
			.o_rd_data(rd_beat[g])
		);

		tx_port_lookup tx_port_lookup_inst (
			.i_clk(i_clk),
			.i_arst_n(i_arst_n),
			.i_fifo_valid(rd_valid[g]),
			.o_fifo_ready(rd_ready[g]),
			.i_fifo_beat(rd_beat[g]),
			.o_lkup_req(lkup_req[g]),
			.o_lkup_mac(lkup_mac[g]),
			.i_lkup_ack(lkup_ack[g]),
			.i_lkup_mask(lkup_mask),
			.o_src_valid(src_valid[g]),
			.i_src_ready(src_ready[g]),
			.o_src_beat(src_beat[g]),
			.o_src_mask(src_mask[g])
		);
	end

	// Shared table for all ports
	route_table route_table_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_learn_valid(learn_valid),
		.o_learn_ready(learn_ready),
		.i_learn_mac(learn_mac),
		.i_learn_port(learn_port),
		.i_lkup_req(lkup_req),
		.i_lkup_mac(lkup_mac),
		.o_lkup_ack(lkup_ack),
		.o_lkup_mask(lkup_mask)
	);

	tx_crossbar tx_crossbar_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_src_valid(src_valid),
		.o_src_ready(src_ready),
		.i_src_beat(src_beat),
		.i_src_mask(src_mask),
		.o_tx_valid(o_tx_valid),
		.i_tx_ready(i_tx_ready),
		.o_tx_data(o_tx_data),
		.o_tx_bytes(o_tx_bytes),
		.o_tx_last(o_tx_last)
	);

endmodule

//--- hdl/tx_crossbar.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module tx_crossbar
	import sw_pkg::*;
(
	input logic i_clk,
	input logic i_arst_n,
	// Routed sources, one per port
	input portmask_t i_src_valid,
	output portmask_t o_src_ready,
	input beat_t [`SW_NETH-1:0] i_src_beat,
	input portmask_t [`SW_NETH-1:0] i_src_mask,
	// Transmit outputs
	output logic [`SW_NETH-1:0] o_tx_valid,
	input logic [`SW_NETH-1:0] i_tx_ready,
	output logic [`SW_NETH-1:0][`SW_BEATW-1:0] o_tx_data,
	output logic [`SW_NETH-1:0][`SW_BYTEW-1:0] o_tx_bytes,
	output logic [`SW_NETH-1:0] o_tx_last
);

	portidx_t gnt_r [`SW_NETH];
	logic [`SW_NETH-1:0] lock;
	portmask_t req [`SW_NETH];
	portidx_t cur_gnt [`SW_NETH];
	logic [`SW_NETH-1:0] has;
	portmask_t fire;

	always_comb
	begin
		// Requests seen by each output
		for (int o = 0; o < `SW_NETH; o++)
		begin
			for (int s = 0; s < `SW_NETH; s++)
				req[o][s] = i_src_valid[s] && i_src_mask[s][o];
			// Locked output keeps its source, else lowest requester
			cur_gnt[o] = gnt_r[o];
			if (!lock[o])
			begin
				cur_gnt[o] = '0;
				for (int s = `SW_NETH-1; s >= 0; s--)
					if (req[o][s])
						cur_gnt[o] = portidx_t'(s);
			end
			has[o] = lock[o] || (|req[o]);
		end

		// Beat released only when every destination is granted and ready
		for (int s = 0; s < `SW_NETH; s++)
		begin
			fire[s] = i_src_valid[s] && (|i_src_mask[s]);
			for (int o = 0; o < `SW_NETH; o++)
				if (i_src_mask[s][o] &&
						!(has[o] && (cur_gnt[o] == portidx_t'(s)) && i_tx_ready[o]))
					fire[s] = 1'b0;
		end

		// Output side mux
		for (int o = 0; o < `SW_NETH; o++)
		begin
			o_tx_valid[o] = has[o] && fire[cur_gnt[o]] && i_src_mask[cur_gnt[o]][o];
			o_tx_data[o] = i_src_beat[cur_gnt[o]].data;
			o_tx_bytes[o] = i_src_beat[cur_gnt[o]].bytes;
			o_tx_last[o] = i_src_beat[cur_gnt[o]].last;
		end
	end

	assign o_src_ready = fire;

	// Lock set by a moving non-last beat, cleared after the last one
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			lock <= '0;
			for (int o = 0; o < `SW_NETH; o++)
				gnt_r[o] <= '0;
		end
		else
		begin
			for (int o = 0; o < `SW_NETH; o++)
				if (o_tx_valid[o] && i_tx_ready[o])
				begin
					gnt_r[o] <= cur_gnt[o];
					lock[o] <= !o_tx_last[o];
				end
		end
	end

	// Grant holds steady on each output across a frame
	for (genvar go = 0; go < `SW_NETH; go++)
	begin : g_gnt_chk
		a_gnt_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			lock[go] |=> gnt_r[go] == $past(gnt_r[go]));
	end

endmodule

//--- hdl/tx_port_lookup.sv
`timescale 1ns/1ps
`include "sw_defines.svh"

module tx_port_lookup
	import sw_pkg::*;
(
	input logic i_clk,
	input logic i_arst_n,
	// Head of the frame FIFO
	input logic i_fifo_valid,
	output logic o_fifo_ready,
	input beat_t i_fifo_beat,
	// Route table lookup
	output logic o_lkup_req,
	output mac_t o_lkup_mac,
	input logic i_lkup_ack,
	input portmask_t i_lkup_mask,
	// Routed stream toward the crossbar
	output logic o_src_valid,
	input logic i_src_ready,
	output beat_t o_src_beat,
	output portmask_t o_src_mask
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_WAIT,
		S_XFER
	} state_t;

	state_t state;
	portmask_t mask_r;
	logic has_dest;
	logic head_pop;

	// Empty mask means the frame is only drained
	assign has_dest = |mask_r;

	// Destination MAC is the first six bytes of the head beat
	assign o_lkup_req = (state == S_WAIT);
	assign o_lkup_mac = i_fifo_beat.data[`SW_BEATW-1 -: `SW_MACW];

	assign o_src_valid = (state == S_XFER) && has_dest && i_fifo_valid;
	assign o_src_beat = i_fifo_beat;
	assign o_src_mask = mask_r;

	always_comb
	begin
		o_fifo_ready = 1'b0;
		if (state == S_XFER)
			o_fifo_ready = has_dest ? i_src_ready : 1'b1;
	end

	assign head_pop = i_fifo_valid && o_fifo_ready;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state <= S_IDLE;
			mask_r <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					// Head beat is always the start of a frame here
					if (i_fifo_valid)
						state <= S_WAIT;
				end
				S_WAIT:
				begin
					// Mask held for the whole frame
					if (i_lkup_ack)
					begin
						mask_r <= i_lkup_mask;
						state <= S_XFER;
					end
				end
				S_XFER:
				begin
					if (head_pop && i_fifo_beat.last)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule
